// File: include/axi_rd_defs.svh
`ifndef AXI_RD_DEFS_SVH
`define AXI_RD_DEFS_SVH

// ------------------------------
// AXI field widths
// ------------------------------
`define AXI_ID_WIDTH    4
`define AXI_ADDR_WIDTH  16
`define AXI_DATA_WIDTH  32
`define AXI_LEN_WIDTH   8
`define AXI_SIZE_WIDTH  3
`define AXI_BURST_WIDTH 2
`define AXI_RESP_WIDTH  2

// ------------------------------
// Slave sizing and fetch model
// ------------------------------
`define AXI_OST_DEPTH   4     // Outstanding request slots
`define AXI_MAX_BURST   8     // Beats per burst, upper bound
`define AXI_FETCH_DLY   24    // Base memory latency in cycles
`define AXI_ERR_ID      15    // Last beat of this ID is SLVERR

// Burst type codes
`define AXI_BURST_FIXED 2'b00
`define AXI_BURST_INCR  2'b01
`define AXI_BURST_WRAP  2'b10

// Response codes
`define AXI_RESP_OKAY   2'b00
`define AXI_RESP_SLVERR 2'b10

`endif

// File: design/axi_rd_pkg.sv
`default_nettype none

`include "axi_rd_defs.svh"

package axi_rd_pkg;

    // ------------------------------
    // Field vectors
    // ------------------------------
    typedef logic [`AXI_ID_WIDTH-1:0]    axi_id_t;
    typedef logic [`AXI_ADDR_WIDTH-1:0]  axi_addr_t;
    typedef logic [`AXI_DATA_WIDTH-1:0]  axi_data_t;
    typedef logic [`AXI_LEN_WIDTH-1:0]   axi_len_t;
    typedef logic [`AXI_SIZE_WIDTH-1:0]  axi_size_t;
    typedef logic [`AXI_BURST_WIDTH-1:0] axi_burst_t;
    typedef logic [`AXI_RESP_WIDTH-1:0]  axi_resp_t;

    // Slot bookkeeping
    typedef logic [$clog2(`AXI_OST_DEPTH)-1:0]   slot_ptr_t;
    typedef logic [`AXI_OST_DEPTH-1:0]           slot_mask_t;
    typedef logic [$clog2(`AXI_MAX_BURST)-1:0]   beat_idx_t;
    typedef logic [$clog2(`AXI_FETCH_DLY+1)-1:0] fetch_cnt_t;

    // ------------------------------
    // Channel payloads
    // ------------------------------
    typedef struct packed {
        axi_id_t    id;
        axi_addr_t  addr;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_t burst;
    } ar_req_t;

    typedef struct packed {
        axi_id_t   id;
        axi_data_t data;
        axi_resp_t resp;
        logic      last;
    } r_beat_t;

    typedef enum logic [1:0] {
        SLOT_IDLE,
        SLOT_FETCH,   // Beats still being fetched
        SLOT_DRAIN    // All fetched, waiting for the last take
    } slot_state_e;

endpackage

`default_nettype wire

// File: design/burst_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_rd_defs.svh"

module burst_addr_gen (
    input  axi_rd_pkg::ar_req_t   req,
    input  axi_rd_pkg::beat_idx_t beat,
    output axi_rd_pkg::axi_addr_t addr
);

    axi_rd_pkg::axi_addr_t nbytes;      // Bytes per beat
    axi_rd_pkg::axi_addr_t aligned;     // Start rounded down to beat size
    axi_rd_pkg::axi_addr_t offset;      // Beat index times beat size
    axi_rd_pkg::axi_addr_t incr_addr;
    axi_rd_pkg::axi_addr_t wrap_mask;   // Window size minus one

    // ------------------------------
    // Address terms
    // ------------------------------
    always_comb begin
        nbytes    = axi_rd_pkg::axi_addr_t'(1) << req.size;
        aligned   = req.addr & ~(nbytes - axi_rd_pkg::axi_addr_t'(1));
        offset    = axi_rd_pkg::axi_addr_t'(beat) << req.size;
        incr_addr = aligned + offset;
        // WRAP lengths are 2, 4, 8 or 16 beats, so the window is a power of two
        wrap_mask = ((axi_rd_pkg::axi_addr_t'(req.len) + axi_rd_pkg::axi_addr_t'(1))
                    << req.size) - axi_rd_pkg::axi_addr_t'(1);
    end

    // ------------------------------
    // Burst type select
    // ------------------------------
    always_comb begin
        if (beat == '0) begin
            addr = req.addr;                            // First beat keeps unaligned start
        end else begin
            case (req.burst)
                `AXI_BURST_FIXED: begin
                    addr = req.addr;
                end
                `AXI_BURST_INCR: begin
                    addr = incr_addr;
                end
                `AXI_BURST_WRAP: begin
                    addr = (aligned & ~wrap_mask) | (incr_addr & wrap_mask);  // Stay in window
                end
                default: begin
                    addr = req.addr;                    // Reserved code
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/rd_slot.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_rd_defs.svh"

module rd_slot (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  accept,
    input  axi_rd_pkg::ar_req_t   req,
    input  logic                  beat_taken,
    output logic                  busy,
    output axi_rd_pkg::axi_id_t   id,
    output logic                  beat_ready,
    output axi_rd_pkg::r_beat_t   beat
);

    axi_rd_pkg::slot_state_e state;
    axi_rd_pkg::ar_req_t     req_q;        // Captured AR payload
    axi_rd_pkg::fetch_cnt_t  fetch_cnt;
    axi_rd_pkg::fetch_cnt_t  fetch_lim;    // Latency for this ID
    axi_rd_pkg::beat_idx_t   fetch_idx;    // Beat being fetched
    axi_rd_pkg::beat_idx_t   send_idx;     // Beat offered on R
    axi_rd_pkg::beat_idx_t   last_idx;
    axi_rd_pkg::axi_addr_t   beat_addr;
    logic                    fetch_hit;
    logic                    is_last;

    axi_rd_pkg::axi_data_t   buf_data [`AXI_MAX_BURST];
    logic [`AXI_MAX_BURST-1:0] buf_vld;

    burst_addr_gen burst_addr_gen_i (
        .req  (req_q),
        .beat (fetch_idx),
        .addr (beat_addr)
    );

    assign fetch_lim = axi_rd_pkg::fetch_cnt_t'(`AXI_FETCH_DLY)
                     - axi_rd_pkg::fetch_cnt_t'(req_q.id);
    assign fetch_hit = (state == axi_rd_pkg::SLOT_FETCH) && (fetch_cnt == fetch_lim);
    assign last_idx  = axi_rd_pkg::beat_idx_t'(req_q.len);
    assign is_last   = send_idx == last_idx;

    // ------------------------------
    // Slot FSM and fetch timer
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= axi_rd_pkg::SLOT_IDLE;
            fetch_cnt <= '0;
            fetch_idx <= '0;
            buf_vld   <= '0;
        end else begin
            case (state)
                axi_rd_pkg::SLOT_IDLE: begin
                    if (accept) begin
                        state     <= axi_rd_pkg::SLOT_FETCH;
                        fetch_cnt <= axi_rd_pkg::fetch_cnt_t'(1);  // Delay counts from accept
                        fetch_idx <= '0;
                        buf_vld   <= '0;
                    end
                end
                axi_rd_pkg::SLOT_FETCH: begin
                    if (fetch_hit) begin
                        buf_vld[fetch_idx] <= 1'b1;
                        fetch_cnt          <= axi_rd_pkg::fetch_cnt_t'(1);  // Next beat restarts
                        fetch_idx          <= fetch_idx + 1'b1;
                        if (fetch_idx == last_idx) begin
                            state <= axi_rd_pkg::SLOT_DRAIN;
                        end
                    end else begin
                        fetch_cnt <= fetch_cnt + 1'b1;
                    end
                end
                axi_rd_pkg::SLOT_DRAIN: begin
                    if (beat_taken && is_last) begin
                        state <= axi_rd_pkg::SLOT_IDLE;      // Frees on the final take
                    end
                end
                default: begin
                    state <= axi_rd_pkg::SLOT_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            send_idx <= '0;
        end else if (accept) begin
            send_idx <= '0;
        end else if (beat_taken) begin
            send_idx <= send_idx + 1'b1;
        end
    end

    // ------------------------------
    // Request and beat storage
    // ------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_hit) begin
            // Data word is the ID above the beat address
            buf_data[fetch_idx] <= axi_rd_pkg::axi_data_t'({req_q.id, beat_addr});
        end
    end

    // ------------------------------
    // Outputs
    // ------------------------------
    assign busy       = state != axi_rd_pkg::SLOT_IDLE;
    assign id         = req_q.id;
    assign beat_ready = busy && buf_vld[send_idx];

    always_comb begin
        beat.id   = req_q.id;
        beat.data = buf_data[send_idx];
        beat.last = is_last;
        if (is_last && (req_q.id == axi_rd_pkg::axi_id_t'(`AXI_ERR_ID))) begin
            beat.resp = `AXI_RESP_SLVERR;
        end else begin
            beat.resp = `AXI_RESP_OKAY;
        end
    end

    accept_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> state == axi_rd_pkg::SLOT_IDLE);

    take_when_ready: assert property (@(posedge clk) disable iff (!rst_n)
        beat_taken |-> beat_ready);

endmodule

`default_nettype wire

// File: design/id_order.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_rd_defs.svh"

module id_order (
    input  logic                   clk,
    input  logic                   rst_n,
    input  axi_rd_pkg::slot_mask_t accept,
    input  axi_rd_pkg::axi_id_t    ar_id,
    input  axi_rd_pkg::slot_mask_t busy,
    input  axi_rd_pkg::axi_id_t    ids [`AXI_OST_DEPTH],
    output axi_rd_pkg::slot_mask_t eligible
);

    axi_rd_pkg::slot_mask_t older [`AXI_OST_DEPTH];   // Row i marks slots ahead of slot i
    axi_rd_pkg::slot_mask_t same_id;                  // Busy slots matching the AR ID

    always_comb begin
        for (int j = 0; j < `AXI_OST_DEPTH; j++) begin
            same_id[j] = busy[j] && (ids[j] == ar_id);
        end
    end

    // ------------------------------
    // Age matrix
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `AXI_OST_DEPTH; i++) begin
                older[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `AXI_OST_DEPTH; i++) begin
                if (accept[i]) begin
                    older[i] <= same_id;            // Snapshot of pending same-ID work
                end else begin
                    older[i] <= older[i] & busy;    // Drop freed slots before reuse
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `AXI_OST_DEPTH; i++) begin
            eligible[i] = ~|(older[i] & busy);
        end
    end

    // One beat stream per ID may be offered at a time
    for (genvar i = 0; i < `AXI_OST_DEPTH; i++) begin : g_row
        for (genvar j = i + 1; j < `AXI_OST_DEPTH; j++) begin : g_col
            one_per_id: assert property (@(posedge clk) disable iff (!rst_n)
                !(busy[i] && busy[j] && eligible[i] && eligible[j] && (ids[i] == ids[j])));
        end
    end

endmodule

`default_nettype wire

// File: design/slot_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_rd_defs.svh"

module slot_arbiter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  axi_rd_pkg::slot_mask_t request,
    input  logic                   taken,
    output axi_rd_pkg::slot_ptr_t  grant,
    output logic                   grant_valid
);

    axi_rd_pkg::slot_mask_t taken_mask;
    axi_rd_pkg::slot_mask_t req_eff;     // Request without the beat just taken
    axi_rd_pkg::slot_ptr_t  cand;
    axi_rd_pkg::slot_ptr_t  nxt_grant;
    logic                   nxt_valid;

    always_comb begin
        taken_mask = '0;
        if (taken) begin
            taken_mask[grant] = 1'b1;    // Its request still shows the old beat
        end
        req_eff   = request & ~taken_mask;
        nxt_grant = grant;
        nxt_valid = 1'b0;
        cand      = grant;
        if (grant_valid && req_eff[grant]) begin
            nxt_valid = 1'b1;            // Hold under back-pressure
        end else begin
            // Walk down so the nearest slot after grant wins
            for (int k = `AXI_OST_DEPTH; k >= 1; k--) begin
                cand = grant + axi_rd_pkg::slot_ptr_t'(k);
                if (req_eff[cand]) begin
                    nxt_grant = cand;
                    nxt_valid = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant       <= '0;
            grant_valid <= 1'b0;
        end else begin
            grant       <= nxt_grant;
            grant_valid <= nxt_valid;
        end
    end

    grant_hold: assert property (@(posedge clk) disable iff (!rst_n)
        grant_valid && !taken |=> grant_valid && $stable(grant));

endmodule

`default_nettype wire

// File: design/axi_rd_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_rd_defs.svh"

module axi_rd_slave (
    input  logic                clk,
    input  logic                rst_n,
    // Read address channel
    input  axi_rd_pkg::ar_req_t ar,
    input  logic                arvalid,
    output logic                arready,
    // Read data channel
    output axi_rd_pkg::r_beat_t r,
    output logic                rvalid,
    input  logic                rready
);

    axi_rd_pkg::slot_mask_t busy;
    axi_rd_pkg::slot_mask_t beat_ready;
    axi_rd_pkg::slot_mask_t eligible;
    axi_rd_pkg::slot_mask_t accept;
    axi_rd_pkg::slot_mask_t beat_taken;
    axi_rd_pkg::axi_id_t    slot_id   [`AXI_OST_DEPTH];
    axi_rd_pkg::r_beat_t    slot_beat [`AXI_OST_DEPTH];
    axi_rd_pkg::slot_ptr_t  free_ptr;
    axi_rd_pkg::slot_ptr_t  grant;
    logic                   grant_valid;
    logic                   ar_fire;
    logic                   r_fire;

    // ------------------------------
    // Free slot and strobes
    // ------------------------------
    always_comb begin
        free_ptr = '0;
        for (int i = `AXI_OST_DEPTH - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_ptr = axi_rd_pkg::slot_ptr_t'(i);   // Lowest free index wins
            end
        end
    end

    assign arready = ~&busy;
    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    // ------------------------------
    // Slot array
    // ------------------------------
    for (genvar g = 0; g < `AXI_OST_DEPTH; g++) begin : g_slot
        assign accept[g]     = ar_fire && (free_ptr == axi_rd_pkg::slot_ptr_t'(g));
        assign beat_taken[g] = r_fire && (grant == axi_rd_pkg::slot_ptr_t'(g));

        rd_slot rd_slot_i (
            .clk        (clk),
            .rst_n      (rst_n),
            .accept     (accept[g]),
            .req        (ar),
            .beat_taken (beat_taken[g]),
            .busy       (busy[g]),
            .id         (slot_id[g]),
            .beat_ready (beat_ready[g]),
            .beat       (slot_beat[g])
        );
    end

    id_order id_order_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .accept   (accept),
        .ar_id    (ar.id),
        .busy     (busy),
        .ids      (slot_id),
        .eligible (eligible)
    );

    slot_arbiter slot_arbiter_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .request     (beat_ready & eligible),
        .taken       (r_fire),
        .grant       (grant),
        .grant_valid (grant_valid)
    );

    // R channel from the granted slot
    assign r      = slot_beat[grant];
    assign rvalid = grant_valid;

    r_stable: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(r));

endmodule

`default_nettype wire

// File: sim/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst_n
);

    localparam realtime HALF_PERIOD = 4ns;   // 8 ns clock
    localparam int      RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;                        // Release on a rising edge
    end

endmodule

`default_nettype wire

// File: sim/tb_axi_rd_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_rd_defs.svh"

module tb_axi_rd_slave;

    localparam int NUM_REQ         = 200;
    localparam int WATCHDOG_CYCLES = NUM_REQ * `AXI_MAX_BURST * 40;

    logic                clk;
    logic                rst_n;
    axi_rd_pkg::ar_req_t ar      = '0;
    logic                arvalid = 1'b0;
    logic                arready;
    axi_rd_pkg::r_beat_t r;
    logic                rvalid;
    logic                rready  = 1'b0;

    integer              seed = 32'hfe46;
    axi_rd_pkg::r_beat_t exp_q [1 << `AXI_ID_WIDTH][$];   // Expected beats per ID
    axi_rd_pkg::ar_req_t next_req;
    axi_rd_pkg::r_beat_t held_r;
    axi_rd_pkg::r_beat_t exp_beat;
    logic                ar_fire_seen = 1'b0;   // AR handshake on the coming edge
    logic                hold_r       = 1'b0;   // R stalled on the coming edge
    int                  sent         = 0;
    int                  outstanding  = 0;
    int                  done_cnt     = 0;

    clk_gen clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    axi_rd_slave axi_rd_slave_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    // ------------------------------
    // Reporting
    // ------------------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("ERROR %s expected 0x%0h actual 0x%0h", name, expected, actual));
        end
    endtask

    // ------------------------------
    // Stimulus and reference model
    // ------------------------------
    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic make_request(output axi_rd_pkg::ar_req_t req);
        int kind;
        req.id   = axi_rd_pkg::axi_id_t'(rand_below(1 << `AXI_ID_WIDTH));
        req.size = axi_rd_pkg::axi_size_t'(rand_below(3));
        req.addr = axi_rd_pkg::axi_addr_t'(rand_below(1 << `AXI_ADDR_WIDTH));
        kind     = rand_below(3);
        if (kind == 2) begin
            req.burst = `AXI_BURST_WRAP;
            req.len   = axi_rd_pkg::axi_len_t'((2 << rand_below(3)) - 1);   // 2, 4 or 8 beats
            req.addr  = axi_rd_pkg::axi_addr_t'((int'(req.addr) >> req.size) << req.size);
        end else begin
            req.burst = (kind == 0) ? `AXI_BURST_FIXED : `AXI_BURST_INCR;
            req.len   = axi_rd_pkg::axi_len_t'(rand_below(`AXI_MAX_BURST));
        end
    endtask

    function automatic axi_rd_pkg::axi_addr_t model_addr(input axi_rd_pkg::ar_req_t req,
                                                         input int n);
        int bytes;
        int start;
        int first;
        int win;
        int base;
        bytes = 1 << req.size;
        start = int'(req.addr);
        first = (start / bytes) * bytes;
        if (n == 0 || req.burst == `AXI_BURST_FIXED) begin
            return req.addr;
        end
        if (req.burst == `AXI_BURST_INCR) begin
            return axi_rd_pkg::axi_addr_t'(first + n * bytes);
        end
        win  = (int'(req.len) + 1) * bytes;           // Wrap window in bytes
        base = (start / win) * win;
        return axi_rd_pkg::axi_addr_t'(base + (first - base + n * bytes) % win);
    endfunction

    task automatic add_expected(input axi_rd_pkg::ar_req_t req);
        axi_rd_pkg::r_beat_t b;
        for (int n = 0; n <= int'(req.len); n++) begin
            b.id   = req.id;
            b.data = axi_rd_pkg::axi_data_t'({req.id, model_addr(req, n)});
            b.last = (n == int'(req.len));
            b.resp = (b.last && req.id == axi_rd_pkg::axi_id_t'(`AXI_ERR_ID)) ?
                     `AXI_RESP_SLVERR : `AXI_RESP_OKAY;
            exp_q[req.id].push_back(b);
        end
    endtask

    // Drive on the rising edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (!arvalid || ar_fire_seen) begin
                if (sent < NUM_REQ && rand_below(4) != 0) begin
                    make_request(next_req);
                    ar      <= next_req;
                    arvalid <= 1'b1;
                    sent     = sent + 1;
                end else begin
                    arvalid <= 1'b0;
                end
            end
            rready <= (rand_below(3) != 0);       // Frequent back-pressure
        end
    end

    // ------------------------------
    // Monitor, sampled mid-cycle
    // ------------------------------
    always @(negedge clk) begin
        if (rst_n) begin
            compare_value("arready", 64'(outstanding < `AXI_OST_DEPTH), 64'(arready));
            if (outstanding == 0) begin
                compare_value("rvalid", 64'(1'b0), 64'(rvalid));
            end
            if (hold_r) begin
                compare_value("rvalid", 64'(1'b1), 64'(rvalid));
                compare_value("r", 64'(held_r), 64'(r));
            end
            ar_fire_seen = arvalid && arready;
            if (ar_fire_seen) begin
                add_expected(ar);
                outstanding++;
            end
            if (rvalid && rready) begin
                if (exp_q[r.id].size() == 0) begin
                    fail_run($sformatf("Beat for ID %0h arrived with no request pending", r.id));
                end else begin
                    exp_beat = exp_q[r.id].pop_front();   // Oldest beat of this ID
                    compare_value("rdata", 64'(exp_beat.data), 64'(r.data));
                    compare_value("rresp", 64'(exp_beat.resp), 64'(r.resp));
                    compare_value("rlast", 64'(exp_beat.last), 64'(r.last));
                    if (r.last) begin
                        outstanding--;
                        done_cnt++;
                    end
                end
            end
            hold_r = rvalid && !rready;
            held_r = r;
        end
    end

    // ------------------------------
    // Run control
    // ------------------------------
    initial begin
        wait (done_cnt == NUM_REQ);
        @(negedge clk);                            // Monitor sees the drained slave once more
        @(posedge clk);
        $display("TESTS PASSED");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_run($sformatf("Timeout after %0d cycles, only %0d of %0d bursts completed",
                           WATCHDOG_CYCLES, done_cnt, NUM_REQ));
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
design/axi_rd_pkg.sv
design/burst_addr_gen.sv
design/rd_slot.sv
design/id_order.sv
design/slot_arbiter.sv
design/axi_rd_slave.sv
sim/clk_gen.sv
sim/tb_axi_rd_slave.sv

// File: Makefile
# Verilator flow for the AXI read slave testbench

VERILATOR ?= verilator
TOP       ?= tb_axi_rd_slave
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  ?= TESTS PASSED

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

# The run passes only when the pass line shows up in the simulator output
run: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)
